/* logic/exec_pkg.sv */
package exec_pkg;

  // ------------------------------------------------
  // Datapath and buffer sizes
  // ------------------------------------------------

  // Data width
  localparam int unsigned XLEN = 32;

  // ROB entries, one tag per entry
  localparam int unsigned ROB_DEPTH = 8;
  localparam int unsigned ROB_IDX_W = $clog2(ROB_DEPTH);

  // Station entries, kept a power of two so pointers wrap by overflow
  localparam int unsigned RS_DEPTH = 4;
  localparam int unsigned RS_IDX_W = $clog2(RS_DEPTH);

  // ------------------------------------------------
  // Shared types
  // ------------------------------------------------

  // ROB tag
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  // Instruction opcodes
  // MOV passes operand a straight through the ALU
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_MOV = 2'd3
  } op_e;

endpackage

/* logic/issue_ctrl.sv */
`timescale 1ns/100ps

module issue_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  // Issue port
  input  logic                      issue_valid_i,
  input  exec_pkg::op_e             issue_op_i,
  input  logic [exec_pkg::XLEN-1:0] issue_a_i,
  input  logic [exec_pkg::XLEN-1:0] issue_b_i,
  input  exec_pkg::rob_idx_t        issue_src_i,
  output logic                      issue_ready_o,
  // ROB allocation and source lookup
  output logic                      alloc_o,
  input  exec_pkg::rob_idx_t        alloc_tag_i,
  input  logic                      src_busy_i,
  input  logic                      src_done_i,
  input  logic [exec_pkg::XLEN-1:0] src_value_i,
  input  logic                      rob_full_i,
  // ALU path
  output logic                      alu_valid_o,
  output exec_pkg::op_e             alu_op_o,
  output logic [exec_pkg::XLEN-1:0] alu_a_o,
  output logic [exec_pkg::XLEN-1:0] alu_b_o,
  output exec_pkg::rob_idx_t        alu_tag_o,
  input  logic                      alu_ready_i,
  // Station path
  output logic                      rs_valid_o,
  output exec_pkg::rob_idx_t        rs_src_o,
  output exec_pkg::rob_idx_t        rs_dest_o,
  input  logic                      rs_ready_i,
  // CDB snoop for the bypass
  input  logic                      cdb_valid_i,
  input  exec_pkg::rob_idx_t        cdb_tag_i,
  input  logic [exec_pkg::XLEN-1:0] cdb_value_i
);
  import exec_pkg::*;

  logic            flush_q;
  logic            src_hit_cdb;
  logic            src_known;
  logic            to_alu;
  logic            hold;
  logic [XLEN-1:0] mov_value;

  // One idle cycle after a flush while the units settle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      flush_q <= 1'b0;
    end else begin
      flush_q <= flush_i;
    end
  end

  // ------------------------------------------------
  // Source readiness for MOV
  // ------------------------------------------------

  // Broadcast this cycle, station would miss it after the push
  assign src_hit_cdb = cdb_valid_i && (cdb_tag_i == issue_src_i);

  // Not busy means committed, value still held in the ROB
  assign src_known = !src_busy_i || src_done_i || src_hit_cdb;
  assign mov_value = src_hit_cdb ? cdb_value_i : src_value_i;

  // Arithmetic always on the ALU
  assign to_alu = (issue_op_i != OP_MOV) || src_known;

  // ------------------------------------------------
  // Routing and handshake
  // ------------------------------------------------

  assign hold = flush_i || flush_q || rob_full_i;

  assign issue_ready_o = !hold && (to_alu ? alu_ready_i : rs_ready_i);
  assign alloc_o       = issue_valid_i && issue_ready_o;

  // ALU request
  assign alu_valid_o = issue_valid_i && !hold && to_alu;
  assign alu_op_o    = issue_op_i;
  assign alu_a_o     = (issue_op_i == OP_MOV) ? mov_value : issue_a_i;
  assign alu_b_o     = issue_b_i;
  assign alu_tag_o   = alloc_tag_i;

  // Station request, operand always missing here
  assign rs_valid_o = issue_valid_i && !hold && !to_alu;
  assign rs_src_o   = issue_src_i;
  assign rs_dest_o  = alloc_tag_i;

endmodule

/* logic/op_only_rs.sv */
`timescale 1ns/100ps

module op_only_rs (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  // Issue handshake
  input  logic                      issue_valid_i,
  output logic                      issue_ready_o,
  input  exec_pkg::rob_idx_t        rs1_idx_i,
  input  exec_pkg::rob_idx_t        dest_idx_i,
  // CDB snoop
  input  logic                      cdb_valid_i,
  input  exec_pkg::rob_idx_t        cdb_tag_i,
  input  logic [exec_pkg::XLEN-1:0] cdb_value_i,
  // CDB request
  input  logic                      cdb_ready_i,
  output logic                      cdb_valid_o,
  output exec_pkg::rob_idx_t        cdb_tag_o,
  output logic [exec_pkg::XLEN-1:0] cdb_value_o
);
  import exec_pkg::*;

  // Entry status
  logic [RS_DEPTH-1:0] ent_valid;
  logic [RS_DEPTH-1:0] ent_rdy;

  // Entry payload
  rob_idx_t            ent_src   [RS_DEPTH];
  rob_idx_t            ent_dest  [RS_DEPTH];
  logic [XLEN-1:0]     ent_value [RS_DEPTH];

  // Circular pointers
  logic [RS_IDX_W-1:0] head;
  logic [RS_IDX_W-1:0] tail;

  logic push;
  logic pop;

  // ------------------------------------------------
  // Control
  // ------------------------------------------------

  // Free slot at the tail
  assign issue_ready_o = !ent_valid[tail];
  assign push          = issue_valid_i && issue_ready_o;

  // Head forwards its operand as the result
  assign cdb_valid_o = ent_valid[head] && ent_rdy[head];
  assign cdb_tag_o   = ent_dest[head];
  assign cdb_value_o = ent_value[head];
  assign pop         = cdb_valid_o && cdb_ready_i;

  // ------------------------------------------------
  // Status and pointers
  // ------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ent_valid <= '0;
      ent_rdy   <= '0;
      head      <= '0;
      tail      <= '0;
    end else if (flush_i) begin
      ent_valid <= '0;
      ent_rdy   <= '0;
      head      <= '0;
      tail      <= '0;
    end else begin
      // Operand capture, any waiting entry
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (ent_valid[i] && !ent_rdy[i] && cdb_valid_i && (ent_src[i] == cdb_tag_i)) begin
          ent_rdy[i] <= 1'b1;
        end
      end
      // Tail slot is free, so no clash with the capture
      if (push) begin
        ent_valid[tail] <= 1'b1;
        ent_rdy[tail]   <= 1'b0;
        tail            <= tail + 1'b1;
      end
      if (pop) begin
        ent_valid[head] <= 1'b0;
        head            <= head + 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // Payload
  // ------------------------------------------------

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (ent_valid[i] && !ent_rdy[i] && cdb_valid_i && (ent_src[i] == cdb_tag_i)) begin
        ent_value[i] <= cdb_value_i;
      end
    end
    if (push) begin
      ent_src[tail]  <= rs1_idx_i;
      ent_dest[tail] <= dest_idx_i;
    end
  end

endmodule

/* logic/alu_pipe.sv */
`timescale 1ns/100ps

module alu_pipe (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  // Issue side
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  exec_pkg::op_e             op_i,
  input  logic [exec_pkg::XLEN-1:0] a_i,
  input  logic [exec_pkg::XLEN-1:0] b_i,
  input  exec_pkg::rob_idx_t        tag_i,
  // CDB side
  input  logic                      out_ready_i,
  output logic                      out_valid_o,
  output exec_pkg::rob_idx_t        out_tag_o,
  output logic [exec_pkg::XLEN-1:0] out_value_o
);
  import exec_pkg::*;

  logic            s1_valid;
  op_e             s1_op;
  logic [XLEN-1:0] s1_a;
  logic [XLEN-1:0] s1_b;
  rob_idx_t        s1_tag;
  logic [XLEN-1:0] s1_res;
  logic            adv;

  // Whole pipe holds on a lost grant
  assign adv        = !out_valid_o || out_ready_i;
  assign in_ready_o = adv;

  // Stage 1 result
  always_comb begin
    case (s1_op)
      OP_ADD:  s1_res = s1_a + s1_b;
      OP_SUB:  s1_res = s1_a - s1_b;
      OP_XOR:  s1_res = s1_a ^ s1_b;
      default: s1_res = s1_a;
    endcase
  end

  // Valid bits
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid    <= 1'b0;
      out_valid_o <= 1'b0;
    end else if (flush_i) begin
      s1_valid    <= 1'b0;
      out_valid_o <= 1'b0;
    end else if (adv) begin
      s1_valid    <= in_valid_i;
      out_valid_o <= s1_valid;
    end
  end

  // Operands and result
  always_ff @(posedge clk_i) begin
    if (adv) begin
      s1_op       <= op_i;
      s1_a        <= a_i;
      s1_b        <= b_i;
      s1_tag      <= tag_i;
      out_tag_o   <= s1_tag;
      out_value_o <= s1_res;
    end
  end

endmodule

/* logic/cdb_arbiter.sv */
`timescale 1ns/100ps

module cdb_arbiter (
  // ALU request, highest priority
  input  logic                      alu_valid_i,
  input  exec_pkg::rob_idx_t        alu_tag_i,
  input  logic [exec_pkg::XLEN-1:0] alu_value_i,
  output logic                      alu_ready_o,
  // Station request
  input  logic                      rs_valid_i,
  input  exec_pkg::rob_idx_t        rs_tag_i,
  input  logic [exec_pkg::XLEN-1:0] rs_value_i,
  output logic                      rs_ready_o,
  // Bus
  output logic                      cdb_valid_o,
  output exec_pkg::rob_idx_t        cdb_tag_o,
  output logic [exec_pkg::XLEN-1:0] cdb_value_o
);

  // Grants
  assign alu_ready_o = 1'b1;
  assign rs_ready_o  = !alu_valid_i;

  // Winner on the bus
  assign cdb_valid_o = alu_valid_i || rs_valid_i;
  assign cdb_tag_o   = alu_valid_i ? alu_tag_i : rs_tag_i;
  assign cdb_value_o = alu_valid_i ? alu_value_i : rs_value_i;

endmodule

/* logic/rob.sv */
`timescale 1ns/100ps

module rob (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  // Allocation
  input  logic                      alloc_i,
  output exec_pkg::rob_idx_t        alloc_tag_o,
  output logic                      full_o,
  // Source lookup
  input  exec_pkg::rob_idx_t        src_tag_i,
  output logic                      src_busy_o,
  output logic                      src_done_o,
  output logic [exec_pkg::XLEN-1:0] src_value_o,
  // Write-back
  input  logic                      cdb_valid_i,
  input  exec_pkg::rob_idx_t        cdb_tag_i,
  input  logic [exec_pkg::XLEN-1:0] cdb_value_i,
  // Commit port
  output logic                      commit_valid_o,
  output exec_pkg::rob_idx_t        commit_tag_o,
  output logic [exec_pkg::XLEN-1:0] commit_value_o,
  input  logic                      commit_ready_i
);
  import exec_pkg::*;

  logic [ROB_DEPTH-1:0] busy;
  logic [ROB_DEPTH-1:0] done;
  logic [XLEN-1:0]      value [ROB_DEPTH];
  rob_idx_t             head;
  rob_idx_t             tail;
  logic [ROB_IDX_W:0]   count;
  logic                 commit;

  // ------------------------------------------------
  // Status outputs
  // ------------------------------------------------

  assign full_o      = (count == ROB_DEPTH[ROB_IDX_W:0]);
  assign alloc_tag_o = tail;

  assign src_busy_o  = busy[src_tag_i];
  assign src_done_o  = done[src_tag_i];
  assign src_value_o = value[src_tag_i];

  // Head commits once written back
  assign commit_valid_o = busy[head] && done[head];
  assign commit_tag_o   = head;
  assign commit_value_o = value[head];
  assign commit         = commit_valid_o && commit_ready_i;

  // ------------------------------------------------
  // Entry state and pointers
  // ------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy  <= '0;
      done  <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush_i) begin
      busy  <= '0;
      done  <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      // Bus tag always owns a busy entry
      if (cdb_valid_i) begin
        done[cdb_tag_i] <= 1'b1;
      end
      // Tail entry is free here, never the write-back target
      if (alloc_i) begin
        busy[tail] <= 1'b1;
        done[tail] <= 1'b0;
        tail       <= tail + 1'b1;
      end
      // Value stays for late MOV lookups
      if (commit) begin
        busy[head] <= 1'b0;
        head       <= head + 1'b1;
      end
      count <= count + (ROB_IDX_W + 1)'(alloc_i) - (ROB_IDX_W + 1)'(commit);
    end
  end

  // Result storage
  always_ff @(posedge clk_i) begin
    if (cdb_valid_i) begin
      value[cdb_tag_i] <= cdb_value_i;
    end
  end

endmodule

/* logic/exec_top.sv */
`timescale 1ns/100ps

module exec_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  // Issue port
  input  logic                      issue_valid_i,
  input  exec_pkg::op_e             issue_op_i,
  input  logic [exec_pkg::XLEN-1:0] issue_a_i,
  input  logic [exec_pkg::XLEN-1:0] issue_b_i,
  input  exec_pkg::rob_idx_t        issue_src_i,
  output logic                      issue_ready_o,
  // Commit port
  output logic                      commit_valid_o,
  output exec_pkg::rob_idx_t        commit_tag_o,
  output logic [exec_pkg::XLEN-1:0] commit_value_o,
  input  logic                      commit_ready_i
);
  import exec_pkg::*;

  // ------------------------------------------------
  // Interconnect
  // ------------------------------------------------

  // ROB allocation and lookup
  logic            alloc;
  rob_idx_t        alloc_tag;
  logic            rob_full;
  logic            src_busy;
  logic            src_done;
  logic [XLEN-1:0] src_value;

  // ALU path
  logic            alu_valid;
  logic            alu_ready;
  op_e             alu_op;
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  rob_idx_t        alu_tag;

  // Station path
  logic            rs_valid;
  logic            rs_ready;
  rob_idx_t        rs_src;
  rob_idx_t        rs_dest;

  // CDB requests
  logic            alu_cdb_valid;
  logic            alu_cdb_ready;
  rob_idx_t        alu_cdb_tag;
  logic [XLEN-1:0] alu_cdb_value;
  logic            rs_cdb_valid;
  logic            rs_cdb_ready;
  rob_idx_t        rs_cdb_tag;
  logic [XLEN-1:0] rs_cdb_value;

  // CDB
  logic            cdb_valid;
  rob_idx_t        cdb_tag;
  logic [XLEN-1:0] cdb_value;

  // ------------------------------------------------
  // Units
  // ------------------------------------------------

  issue_ctrl u_issue_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .issue_valid_i(issue_valid_i),
    .issue_op_i   (issue_op_i),
    .issue_a_i    (issue_a_i),
    .issue_b_i    (issue_b_i),
    .issue_src_i  (issue_src_i),
    .issue_ready_o(issue_ready_o),
    .alloc_o      (alloc),
    .alloc_tag_i  (alloc_tag),
    .src_busy_i   (src_busy),
    .src_done_i   (src_done),
    .src_value_i  (src_value),
    .rob_full_i   (rob_full),
    .alu_valid_o  (alu_valid),
    .alu_op_o     (alu_op),
    .alu_a_o      (alu_a),
    .alu_b_o      (alu_b),
    .alu_tag_o    (alu_tag),
    .alu_ready_i  (alu_ready),
    .rs_valid_o   (rs_valid),
    .rs_src_o     (rs_src),
    .rs_dest_o    (rs_dest),
    .rs_ready_i   (rs_ready),
    .cdb_valid_i  (cdb_valid),
    .cdb_tag_i    (cdb_tag),
    .cdb_value_i  (cdb_value)
  );

  op_only_rs u_op_only_rs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .issue_valid_i(rs_valid),
    .issue_ready_o(rs_ready),
    .rs1_idx_i    (rs_src),
    .dest_idx_i   (rs_dest),
    .cdb_valid_i  (cdb_valid),
    .cdb_tag_i    (cdb_tag),
    .cdb_value_i  (cdb_value),
    .cdb_ready_i  (rs_cdb_ready),
    .cdb_valid_o  (rs_cdb_valid),
    .cdb_tag_o    (rs_cdb_tag),
    .cdb_value_o  (rs_cdb_value)
  );

  alu_pipe u_alu_pipe (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .in_valid_i (alu_valid),
    .in_ready_o (alu_ready),
    .op_i       (alu_op),
    .a_i        (alu_a),
    .b_i        (alu_b),
    .tag_i      (alu_tag),
    .out_ready_i(alu_cdb_ready),
    .out_valid_o(alu_cdb_valid),
    .out_tag_o  (alu_cdb_tag),
    .out_value_o(alu_cdb_value)
  );

  cdb_arbiter u_cdb_arbiter (
    .alu_valid_i(alu_cdb_valid),
    .alu_tag_i  (alu_cdb_tag),
    .alu_value_i(alu_cdb_value),
    .alu_ready_o(alu_cdb_ready),
    .rs_valid_i (rs_cdb_valid),
    .rs_tag_i   (rs_cdb_tag),
    .rs_value_i (rs_cdb_value),
    .rs_ready_o (rs_cdb_ready),
    .cdb_valid_o(cdb_valid),
    .cdb_tag_o  (cdb_tag),
    .cdb_value_o(cdb_value)
  );

  rob u_rob (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .alloc_i       (alloc),
    .alloc_tag_o   (alloc_tag),
    .full_o        (rob_full),
    .src_tag_i     (issue_src_i),
    .src_busy_o    (src_busy),
    .src_done_o    (src_done),
    .src_value_o   (src_value),
    .cdb_valid_i   (cdb_valid),
    .cdb_tag_i     (cdb_tag),
    .cdb_value_i   (cdb_value),
    .commit_valid_o(commit_valid_o),
    .commit_tag_o  (commit_tag_o),
    .commit_value_o(commit_value_o),
    .commit_ready_i(commit_ready_i)
  );

endmodule

/* tb/clk_rst_gen.sv */
`timescale 1ns/100ps

module clk_rst_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  // Reset held low for 5 cycles
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* tb/exec_properties.sv */
`timescale 1ns/100ps

module exec_properties (
  input logic                            clk_i,
  input logic                            rst_n_i,
  input logic                            flush_i,
  input logic [exec_pkg::RS_DEPTH-1:0]   ent_valid_i,
  input exec_pkg::rob_idx_t              ent_src_i [exec_pkg::RS_DEPTH],
  input logic [exec_pkg::RS_IDX_W-1:0]   head_i,
  input logic [exec_pkg::RS_IDX_W-1:0]   tail_i,
  input logic                            push_i,
  input logic                            snoop_valid_i,
  input exec_pkg::rob_idx_t              snoop_tag_i,
  input logic [exec_pkg::XLEN-1:0]       snoop_value_i,
  input logic                            out_valid_i,
  input logic [exec_pkg::XLEN-1:0]       out_value_i
);

  // ------------------------------------------------
  // Station invariants
  // ------------------------------------------------

  // Equal pointers on a push mean an empty ring
  // Otherwise the head entry must be live
  a_push_free: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> ((head_i == tail_i) ? (ent_valid_i == '0) : ent_valid_i[head_i]))
    else $error("station push into a full ring or behind a stale head");

  // New bus request on a held head follows a capture of its source
  a_head_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    (out_valid_i && !$past(out_valid_i) && (head_i == $past(head_i)))
    |-> ($past(snoop_valid_i && (snoop_tag_i == ent_src_i[head_i]))
         && (out_value_i == $past(snoop_value_i))))
    else $error("station drives the CDB without its operand");

  // Issue side keeps pushes out of a flush cycle
  a_flush_push: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |-> !push_i)
    else $error("station push in a flush cycle");

endmodule

bind op_only_rs exec_properties props0 (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .flush_i      (flush_i),
  .ent_valid_i  (ent_valid),
  .ent_src_i    (ent_src),
  .head_i       (head),
  .tail_i       (tail),
  .push_i       (push),
  .snoop_valid_i(cdb_valid_i),
  .snoop_tag_i  (cdb_tag_i),
  .snoop_value_i(cdb_value_i),
  .out_valid_i  (cdb_valid_o),
  .out_value_i  (cdb_value_o)
);

/* tb/exec_tb.sv */
`timescale 1ns/100ps

module exec_tb;
  import exec_pkg::*;

  localparam int unsigned NUM_COMMITS = 2000;
  localparam int unsigned WAIT_LIMIT  = 300;

  logic            clk;
  logic            rst_n;
  logic            flush;
  logic            issue_valid;
  op_e             issue_op;
  logic [XLEN-1:0] issue_a;
  logic [XLEN-1:0] issue_b;
  rob_idx_t        issue_src;
  logic            issue_ready;
  logic            commit_valid;
  rob_idx_t        commit_tag;
  logic [XLEN-1:0] commit_value;
  logic            commit_ready;

  // Reference model state
  rob_idx_t        exp_tag_q [$];
  logic [XLEN-1:0] exp_val_q [$];
  logic [XLEN-1:0] hist_val  [ROB_DEPTH];
  rob_idx_t        next_tag;
  int unsigned     since_flush;
  int unsigned     mov_burst;
  int unsigned     commits;

  // Handshake and timeout tracking
  logic            issue_fired;
  logic            post_flush;
  logic            stalled;
  rob_idx_t        stall_tag;
  logic [XLEN-1:0] stall_value;
  int unsigned     commit_wait;
  int unsigned     issue_wait;
  logic [XLEN-1:0] new_val;

  clk_rst_gen clkgen0 (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  exec_top dut0 (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .flush_i       (flush),
    .issue_valid_i (issue_valid),
    .issue_op_i    (issue_op),
    .issue_a_i     (issue_a),
    .issue_b_i     (issue_b),
    .issue_src_i   (issue_src),
    .issue_ready_o (issue_ready),
    .commit_valid_o(commit_valid),
    .commit_tag_o  (commit_tag),
    .commit_value_o(commit_value),
    .commit_ready_i(commit_ready)
  );

  // ------------------------------------------------
  // Failure reporting and compares
  // ------------------------------------------------

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic wrong_value(input string msg);
    stop_run($sformatf("error at %0t ns: %s", $time, msg));
  endtask

  task automatic check_commit(input rob_idx_t got_tag, input logic [XLEN-1:0] got_val,
                              input rob_idx_t exp_tag, input logic [XLEN-1:0] exp_val);
    if ((got_tag !== exp_tag) || (got_val !== exp_val)) begin
      wrong_value($sformatf("commit tag %0d value %h, expected tag %0d value %h",
                            got_tag, got_val, exp_tag, exp_val));
    end
  endtask

  task automatic check_idle(input string what, input logic got);
    if (got !== 1'b0) begin
      wrong_value($sformatf("%s is high, expected low", what));
    end
  endtask

  // Result of an arithmetic op
  function automatic logic [XLEN-1:0] alu_model(input op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      default: return a ^ b;
    endcase
  endfunction

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------

  task automatic drive_next();
    int unsigned k;
    int unsigned pick;
    int unsigned reach;
    reach = (since_flush < ROB_DEPTH - 1) ? since_flush : ROB_DEPTH - 1;
    if ((mov_burst == 0) && ($urandom_range(0, 7) == 0)) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= 1'b1;
      issue_a     <= $urandom();
      issue_b     <= $urandom();
      if (since_flush == 0) begin
        // Nothing to name yet
        issue_op  <= op_e'($urandom_range(0, 2));
        issue_src <= rob_idx_t'($urandom_range(0, ROB_DEPTH - 1));
      end else if (mov_burst > 0) begin
        mov_burst = mov_burst - 1;
        issue_op  <= OP_MOV;
        issue_src <= next_tag - 1'b1;
      end else begin
        pick = $urandom_range(0, 19);
        if (pick == 0) begin
          // Chain of MOVs, each on the one before
          mov_burst = $urandom_range(2, 5);
          issue_op  <= OP_MOV;
          issue_src <= next_tag - 1'b1;
        end else if (pick < 5) begin
          k = $urandom_range(1, reach);
          issue_op  <= OP_MOV;
          issue_src <= next_tag - rob_idx_t'(k);
        end else begin
          issue_op  <= op_e'($urandom_range(0, 2));
          issue_src <= rob_idx_t'($urandom_range(0, ROB_DEPTH - 1));
        end
      end
    end
  endtask

  task automatic clear_model();
    exp_tag_q.delete();
    exp_val_q.delete();
    next_tag    = '0;
    since_flush = 0;
    mov_burst   = 0;
    stalled     = 1'b0;
    issue_fired = 1'b0;
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------

  initial begin
    void'($urandom(32'hb502_ebe2));
    flush        = 1'b0;
    issue_valid  = 1'b0;
    issue_op     = OP_ADD;
    issue_a      = '0;
    issue_b      = '0;
    issue_src    = '0;
    commit_ready = 1'b0;
    commits      = 0;
    commit_wait  = 0;
    issue_wait   = 0;
    post_flush   = 1'b0;
    stall_tag    = '0;
    stall_value  = '0;
    clear_model();

    // Wait for reset release
    for (int i = 0; (i < 100) && !rst_n; i++) begin
      @(posedge clk);
    end
    if (!rst_n) begin
      stop_run("reset was never released");
    end

    @(negedge clk);
    check_idle("commit_valid_o after reset", commit_valid);
    if (!issue_ready) begin
      wrong_value("issue_ready_o is low after reset, expected high");
    end

    while (commits < NUM_COMMITS) begin
      @(posedge clk);
      if (!flush && (since_flush > 4) && ($urandom_range(0, 299) == 0)) begin
        flush        <= 1'b1;
        issue_valid  <= 1'b0;
        commit_ready <= 1'b0;
      end else begin
        flush        <= 1'b0;
        commit_ready <= ($urandom_range(0, 9) < 7);
        if (flush || issue_fired || !issue_valid) begin
          drive_next();
        end
      end

      // Sample the handshakes for the coming edge
      @(negedge clk);
      if (flush) begin
        clear_model();
        post_flush = 1'b1;
      end else begin
        if (post_flush) begin
          check_idle("commit_valid_o after flush", commit_valid);
          check_idle("CDB valid after flush", dut0.cdb_valid);
          post_flush = 1'b0;
        end
        if ((exp_tag_q.size() == ROB_DEPTH) && issue_ready) begin
          wrong_value("issue_ready_o is high while the ROB is full, expected low");
        end
        // A stalled commit must hold
        if (stalled) begin
          if (!commit_valid) begin
            wrong_value("commit_valid_o dropped while the commit was stalled");
          end
          check_commit(commit_tag, commit_value, stall_tag, stall_value);
        end
        stalled = 1'b0;
        if (commit_valid) begin
          if (exp_tag_q.size() == 0) begin
            wrong_value("commit_valid_o is high with no instruction outstanding");
          end
          check_commit(commit_tag, commit_value, exp_tag_q[0], exp_val_q[0]);
          if (commit_ready) begin
            void'(exp_tag_q.pop_front());
            void'(exp_val_q.pop_front());
            commits     = commits + 1;
            commit_wait = 0;
          end else begin
            stalled     = 1'b1;
            stall_tag   = commit_tag;
            stall_value = commit_value;
          end
        end
        issue_fired = issue_valid && issue_ready;
        if (issue_fired) begin
          if (issue_op == OP_MOV) begin
            new_val = hist_val[issue_src];
          end else begin
            new_val = alu_model(issue_op, issue_a, issue_b);
          end
          exp_tag_q.push_back(next_tag);
          exp_val_q.push_back(new_val);
          hist_val[next_tag] = new_val;
          next_tag    = next_tag + 1'b1;
          since_flush = since_flush + 1;
          issue_wait  = 0;
        end else if (issue_valid) begin
          issue_wait = issue_wait + 1;
        end
      end

      // Timeouts on both ports
      commit_wait = commit_wait + 1;
      if (commit_wait > WAIT_LIMIT) begin
        stop_run("timeout while waiting for a commit");
      end
      if (issue_wait > WAIT_LIMIT) begin
        stop_run("timeout while waiting for issue_ready_o");
      end
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* project.f */
logic/exec_pkg.sv
logic/issue_ctrl.sv
logic/op_only_rs.sv
logic/alu_pipe.sv
logic/cdb_arbiter.sv
logic/rob.sv
logic/exec_top.sv
tb/clk_rst_gen.sv
tb/exec_properties.sv
tb/exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= exec_tb
RTL_TOP   ?= exec_top
FILELIST  ?= project.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
